/* hdl/mem_issue_pkg.sv */
package mem_issue_pkg;

    // widths
    localparam int INST_W     = 32;
    localparam int PREG_W     = 5;
    localparam int NUM_PREGS  = 1 << PREG_W;
    localparam int ROB_W      = 5;
    localparam int DATA_W     = 16;
    localparam int IMM_W      = 12;
    localparam int MEM_ADDR_W = 6;

    // instruction field positions
    localparam int OPC_LO = 0;
    localparam int OPC_HI = 1;
    localparam int RD_LO  = 2;
    localparam int RD_HI  = 6;
    localparam int RS1_LO = 7;
    localparam int RS1_HI = 11;
    localparam int RS2_LO = 12;
    localparam int RS2_HI = 16;
    localparam int IMM_LO = 17;
    localparam int IMM_HI = 28;

    // memory micro-op opcodes
    typedef enum logic [1:0] {
        OP_LI = 2'd0,
        OP_LD = 2'd1,
        OP_ST = 2'd2
    } mem_op_e;

endpackage

/* hdl/age_select.sv */
`timescale 1ns/1ps

module age_select import mem_issue_pkg::*; #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         i_req,
    input  logic [ROB_W-1:0]         i_ages [WIDTH],
    output logic                     o_vld,
    output logic [$clog2(WIDTH)-1:0] o_idx
);

    localparam int IDX_W = $clog2(WIDTH);

    logic [ROB_W-1:0] best_age;

    // a is older than b when a - b wraps negative
    function automatic logic is_older(input logic [ROB_W-1:0] a,
                                      input logic [ROB_W-1:0] b);
        logic [ROB_W-1:0] diff;
        diff = a - b;
        return diff[ROB_W-1];
    endfunction

    // linear scan, keeps the oldest requester seen so far
    always_comb begin
        o_vld    = 1'b0;
        o_idx    = '0;
        best_age = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (i_req[i] && (!o_vld || is_older(i_ages[i], best_age))) begin
                o_vld    = 1'b1;
                o_idx    = IDX_W'(i);
                best_age = i_ages[i];
            end
        end
    end

endmodule

/* hdl/dispatch_decode.sv */
`timescale 1ns/1ps

module dispatch_decode import mem_issue_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  logic [INST_W-1:0] i_inst,
    input  logic [ROB_W-1:0]  i_rob_idx,
    input  logic              i_dep_vld,
    input  logic [ROB_W-1:0]  i_dep_rob_idx,
    input  logic              i_q_can_enq,
    input  logic              i_wb_vld,
    input  logic [PREG_W-1:0] i_wb_preg,
    output logic              o_ready,
    output logic              o_enq_vld,
    output mem_op_e           o_enq_op,
    output logic [PREG_W-1:0] o_enq_rd,
    output logic [PREG_W-1:0] o_enq_rs1,
    output logic [PREG_W-1:0] o_enq_rs2,
    output logic [IMM_W-1:0]  o_enq_imm,
    output logic [ROB_W-1:0]  o_enq_rob,
    output logic [ROB_W-1:0]  o_enq_dep_rob,
    output logic [1:0]        o_enq_src_rdy,
    output logic              o_enq_memdep_rdy
);

    // one bit per physical register, set while a write is in flight
    logic [NUM_PREGS-1:0] busy;
    logic                 writes_rd;
    logic                 use_rs1;
    logic                 use_rs2;

    // field split
    assign o_enq_op      = mem_op_e'(i_inst[OPC_HI:OPC_LO]);
    assign o_enq_rd      = i_inst[RD_HI:RD_LO];
    assign o_enq_rs1     = i_inst[RS1_HI:RS1_LO];
    assign o_enq_rs2     = i_inst[RS2_HI:RS2_LO];
    assign o_enq_imm     = i_inst[IMM_HI:IMM_LO];
    assign o_enq_rob     = i_rob_idx;
    assign o_enq_dep_rob = i_dep_rob_idx;

    assign writes_rd = (o_enq_op == OP_LI) || (o_enq_op == OP_LD);
    assign use_rs1   = (o_enq_op == OP_LD) || (o_enq_op == OP_ST);
    assign use_rs2   = (o_enq_op == OP_ST);

    // source is ready if unused, not busy, or written back right now
    assign o_enq_src_rdy[0] = !use_rs1 || !busy[o_enq_rs1] ||
                              (i_wb_vld && (i_wb_preg == o_enq_rs1));
    assign o_enq_src_rdy[1] = !use_rs2 || !busy[o_enq_rs2] ||
                              (i_wb_vld && (i_wb_preg == o_enq_rs2));
    assign o_enq_memdep_rdy = !i_dep_vld;

    // handshake
    assign o_ready   = i_q_can_enq;
    assign o_enq_vld = i_valid && i_q_can_enq;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (i_wb_vld) begin
                busy[i_wb_preg] <= 1'b0;
            end
            // set after clear so a new producer wins
            if (o_enq_vld && writes_rd) begin
                busy[o_enq_rd] <= 1'b1;
            end
        end
    end

    // a producer must not be dispatched over a pending write
    a_no_waw_dispatch: assert property (@(posedge clk) disable iff (rst)
        (o_enq_vld && writes_rd) |->
            (!busy[o_enq_rd] || (i_wb_vld && (i_wb_preg == o_enq_rd))));

endmodule

/* hdl/mem_issue_queue.sv */
`timescale 1ns/1ps

module mem_issue_queue import mem_issue_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_enq_vld,
    input  mem_op_e           i_enq_op,
    input  logic [PREG_W-1:0] i_enq_rd,
    input  logic [PREG_W-1:0] i_enq_rs1,
    input  logic [PREG_W-1:0] i_enq_rs2,
    input  logic [IMM_W-1:0]  i_enq_imm,
    input  logic [ROB_W-1:0]  i_enq_rob,
    input  logic [ROB_W-1:0]  i_enq_dep_rob,
    input  logic [1:0]        i_enq_src_rdy,
    input  logic              i_enq_memdep_rdy,
    input  logic              i_wb_vld,
    input  logic [PREG_W-1:0] i_wb_preg,
    output logic              o_can_enq,
    output logic              o_iss_vld,
    output mem_op_e           o_iss_op,
    output logic [PREG_W-1:0] o_iss_rd,
    output logic [PREG_W-1:0] o_iss_rs1,
    output logic [PREG_W-1:0] o_iss_rs2,
    output logic [IMM_W-1:0]  o_iss_imm,
    output logic [ROB_W-1:0]  o_iss_rob,
    output logic              o_st_issue_vld,
    output logic [ROB_W-1:0]  o_st_issue_rob
);

    localparam int IDX_W = $clog2(DEPTH);

    // entry flags
    logic [DEPTH-1:0] ent_vld;
    logic [DEPTH-1:0] ent_rdy1;
    logic [DEPTH-1:0] ent_rdy2;
    logic [DEPTH-1:0] ent_mdep;
    logic [DEPTH-1:0] ent_ready;

    // entry payload
    mem_op_e           ent_op      [DEPTH];
    logic [PREG_W-1:0] ent_rd      [DEPTH];
    logic [PREG_W-1:0] ent_rs1     [DEPTH];
    logic [PREG_W-1:0] ent_rs2     [DEPTH];
    logic [IMM_W-1:0]  ent_imm     [DEPTH];
    logic [ROB_W-1:0]  ent_rob     [DEPTH];
    logic [ROB_W-1:0]  ent_dep_rob [DEPTH];

    logic             enq_free;
    logic [IDX_W-1:0] enq_idx;
    logic             store_pending;
    logic             sel_vld;
    logic [IDX_W-1:0] sel_idx;
    logic             st_issue;

    assign o_can_enq = enq_free;
    assign ent_ready = ent_vld & ent_rdy1 & ent_rdy2 & ent_mdep;

    assign st_issue       = o_iss_vld && (o_iss_op == OP_ST);
    assign o_st_issue_vld = st_issue;
    assign o_st_issue_rob = o_iss_rob;

    // lowest free slot, and whether the named store is still queued
    always_comb begin
        enq_free      = 1'b0;
        enq_idx       = '0;
        store_pending = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!ent_vld[i]) begin
                enq_free = 1'b1;
                enq_idx  = IDX_W'(i);
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_vld[i] && (ent_op[i] == OP_ST) && (ent_rob[i] == i_enq_dep_rob)) begin
                store_pending = 1'b1;
            end
        end
    end

    age_select #(
        .WIDTH (DEPTH)
    ) u_age_select (
        .i_req  (ent_ready),
        .i_ages (ent_rob),
        .o_vld  (sel_vld),
        .o_idx  (sel_idx)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_vld   <= '0;
            o_iss_vld <= 1'b0;
        end else begin
            o_iss_vld <= sel_vld;
            // writeback and store-issue wakeup
            for (int i = 0; i < DEPTH; i++) begin
                if (i_wb_vld && (ent_rs1[i] == i_wb_preg)) begin
                    ent_rdy1[i] <= 1'b1;
                end
                if (i_wb_vld && (ent_rs2[i] == i_wb_preg)) begin
                    ent_rdy2[i] <= 1'b1;
                end
                if (st_issue && (ent_dep_rob[i] == o_iss_rob)) begin
                    ent_mdep[i] <= 1'b1;
                end
            end
            // exec never stalls, so the entry frees on issue
            if (sel_vld) begin
                ent_vld[sel_idx] <= 1'b0;
            end
            if (i_enq_vld) begin
                ent_vld[enq_idx]  <= 1'b1;
                ent_rdy1[enq_idx] <= i_enq_src_rdy[0];
                ent_rdy2[enq_idx] <= i_enq_src_rdy[1];
                // store already gone from the queue counts as issued
                ent_mdep[enq_idx] <= i_enq_memdep_rdy || !store_pending;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_enq_vld) begin
            ent_op[enq_idx]      <= i_enq_op;
            ent_rd[enq_idx]      <= i_enq_rd;
            ent_rs1[enq_idx]     <= i_enq_rs1;
            ent_rs2[enq_idx]     <= i_enq_rs2;
            ent_imm[enq_idx]     <= i_enq_imm;
            ent_rob[enq_idx]     <= i_enq_rob;
            ent_dep_rob[enq_idx] <= i_enq_dep_rob;
        end
        if (sel_vld) begin
            o_iss_op  <= ent_op[sel_idx];
            o_iss_rd  <= ent_rd[sel_idx];
            o_iss_rs1 <= ent_rs1[sel_idx];
            o_iss_rs2 <= ent_rs2[sel_idx];
            o_iss_imm <= ent_imm[sel_idx];
            o_iss_rob <= ent_rob[sel_idx];
        end
    end

    a_enq_to_free: assert property (@(posedge clk) disable iff (rst)
        i_enq_vld |-> !ent_vld[enq_idx]);

    // entries leave only through issue, one per cycle
    a_one_issue: assert property (@(posedge clk) disable iff (rst)
        $countones($past(ent_vld) & ~ent_vld) == int'(o_iss_vld));

endmodule

/* hdl/mem_agu_exec.sv */
`timescale 1ns/1ps

module mem_agu_exec import mem_issue_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_iss_vld,
    input  mem_op_e           i_iss_op,
    input  logic [PREG_W-1:0] i_iss_rd,
    input  logic [PREG_W-1:0] i_iss_rs1,
    input  logic [PREG_W-1:0] i_iss_rs2,
    input  logic [IMM_W-1:0]  i_iss_imm,
    input  logic [ROB_W-1:0]  i_iss_rob,
    input  logic              i_wb_vld,
    input  logic [PREG_W-1:0] i_wb_preg,
    input  logic [DATA_W-1:0] i_wb_data,
    output logic              o_ex_vld,
    output mem_op_e           o_ex_op,
    output logic [PREG_W-1:0] o_ex_rd,
    output logic [DATA_W-1:0] o_ex_addr,
    output logic [DATA_W-1:0] o_ex_data
);

    logic [DATA_W-1:0] regfile [NUM_PREGS];
    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] rs1_val;
    logic [DATA_W-1:0] rs2_val;

    assign imm_ext = {{(DATA_W - IMM_W){i_iss_imm[IMM_W-1]}}, i_iss_imm};

    // operand read with same-cycle writeback bypass
    assign rs1_val = (i_wb_vld && (i_wb_preg == i_iss_rs1)) ? i_wb_data : regfile[i_iss_rs1];
    assign rs2_val = (i_wb_vld && (i_wb_preg == i_iss_rs2)) ? i_wb_data : regfile[i_iss_rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regfile[i] <= '0;
            end
        end else if (i_wb_vld) begin
            regfile[i_wb_preg] <= i_wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_ex_vld <= 1'b0;
        end else begin
            o_ex_vld <= i_iss_vld;
        end
        o_ex_op   <= i_iss_op;
        o_ex_rd   <= i_iss_rd;
        o_ex_addr <= rs1_val + imm_ext;
        // LI carries the immediate, ST the store data
        o_ex_data <= (i_iss_op == OP_LI) ? imm_ext : rs2_val;
    end

    // rob index is only carried for scheduling
    a_iss_known: assert property (@(posedge clk) disable iff (rst)
        i_iss_vld |-> !$isunknown({i_iss_op, i_iss_rob}));

endmodule

/* hdl/mem_result_stage.sv */
`timescale 1ns/1ps

module mem_result_stage import mem_issue_pkg::*; #(
    parameter int MEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_ex_vld,
    input  mem_op_e           i_ex_op,
    input  logic [PREG_W-1:0] i_ex_rd,
    input  logic [DATA_W-1:0] i_ex_addr,
    input  logic [DATA_W-1:0] i_ex_data,
    output logic              o_wb_vld,
    output logic [PREG_W-1:0] o_wb_preg,
    output logic [DATA_W-1:0] o_wb_data,
    output logic              o_st_vld,
    output logic [DATA_W-1:0] o_st_addr,
    output logic [DATA_W-1:0] o_st_data
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] dmem [MEM_WORDS];
    logic [AW-1:0]     word_addr;
    logic              is_st;

    // word address wraps with the memory size
    assign word_addr = i_ex_addr[AW-1:0];
    assign is_st     = (i_ex_op == OP_ST);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
            o_wb_vld <= 1'b0;
            o_st_vld <= 1'b0;
        end else begin
            if (i_ex_vld && is_st) begin
                dmem[word_addr] <= i_ex_data;
            end
            o_wb_vld <= i_ex_vld && !is_st;
            o_st_vld <= i_ex_vld && is_st;
        end
        o_wb_preg <= i_ex_rd;
        o_wb_data <= (i_ex_op == OP_LD) ? dmem[word_addr] : i_ex_data;
        o_st_addr <= i_ex_addr;
        o_st_data <= i_ex_data;
    end

    a_wb_st_excl: assert property (@(posedge clk) disable iff (rst)
        !(o_wb_vld && o_st_vld));

endmodule

/* hdl/mem_issue_top.sv */
`timescale 1ns/1ps

module mem_issue_top import mem_issue_pkg::*; #(
    parameter int DEPTH     = 8,
    parameter int MEM_WORDS = 1 << MEM_ADDR_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  logic [INST_W-1:0] i_inst,
    input  logic [ROB_W-1:0]  i_rob_idx,
    input  logic              i_dep_vld,
    input  logic [ROB_W-1:0]  i_dep_rob_idx,
    output logic              o_ready,
    output logic              o_wb_vld,
    output logic [PREG_W-1:0] o_wb_preg,
    output logic [DATA_W-1:0] o_wb_data,
    output logic              o_st_vld,
    output logic [DATA_W-1:0] o_st_addr,
    output logic [DATA_W-1:0] o_st_data,
    output logic              o_st_issue_vld,
    output logic [ROB_W-1:0]  o_st_issue_rob
);

    // decode to queue
    logic              enq_vld;
    mem_op_e           enq_op;
    logic [PREG_W-1:0] enq_rd;
    logic [PREG_W-1:0] enq_rs1;
    logic [PREG_W-1:0] enq_rs2;
    logic [IMM_W-1:0]  enq_imm;
    logic [ROB_W-1:0]  enq_rob;
    logic [ROB_W-1:0]  enq_dep_rob;
    logic [1:0]        enq_src_rdy;
    logic              enq_memdep_rdy;
    logic              q_can_enq;

    // queue to exec
    logic              iss_vld;
    mem_op_e           iss_op;
    logic [PREG_W-1:0] iss_rd;
    logic [PREG_W-1:0] iss_rs1;
    logic [PREG_W-1:0] iss_rs2;
    logic [IMM_W-1:0]  iss_imm;
    logic [ROB_W-1:0]  iss_rob;

    // exec to result
    logic              ex_vld;
    mem_op_e           ex_op;
    logic [PREG_W-1:0] ex_rd;
    logic [DATA_W-1:0] ex_addr;
    logic [DATA_W-1:0] ex_data;

    dispatch_decode u_dispatch_decode (
        .clk              (clk),
        .rst              (rst),
        .i_valid          (i_valid),
        .i_inst           (i_inst),
        .i_rob_idx        (i_rob_idx),
        .i_dep_vld        (i_dep_vld),
        .i_dep_rob_idx    (i_dep_rob_idx),
        .i_q_can_enq      (q_can_enq),
        .i_wb_vld         (o_wb_vld),
        .i_wb_preg        (o_wb_preg),
        .o_ready          (o_ready),
        .o_enq_vld        (enq_vld),
        .o_enq_op         (enq_op),
        .o_enq_rd         (enq_rd),
        .o_enq_rs1        (enq_rs1),
        .o_enq_rs2        (enq_rs2),
        .o_enq_imm        (enq_imm),
        .o_enq_rob        (enq_rob),
        .o_enq_dep_rob    (enq_dep_rob),
        .o_enq_src_rdy    (enq_src_rdy),
        .o_enq_memdep_rdy (enq_memdep_rdy)
    );

    mem_issue_queue #(
        .DEPTH (DEPTH)
    ) u_mem_issue_queue (
        .clk              (clk),
        .rst              (rst),
        .i_enq_vld        (enq_vld),
        .i_enq_op         (enq_op),
        .i_enq_rd         (enq_rd),
        .i_enq_rs1        (enq_rs1),
        .i_enq_rs2        (enq_rs2),
        .i_enq_imm        (enq_imm),
        .i_enq_rob        (enq_rob),
        .i_enq_dep_rob    (enq_dep_rob),
        .i_enq_src_rdy    (enq_src_rdy),
        .i_enq_memdep_rdy (enq_memdep_rdy),
        .i_wb_vld         (o_wb_vld),
        .i_wb_preg        (o_wb_preg),
        .o_can_enq        (q_can_enq),
        .o_iss_vld        (iss_vld),
        .o_iss_op         (iss_op),
        .o_iss_rd         (iss_rd),
        .o_iss_rs1        (iss_rs1),
        .o_iss_rs2        (iss_rs2),
        .o_iss_imm        (iss_imm),
        .o_iss_rob        (iss_rob),
        .o_st_issue_vld   (o_st_issue_vld),
        .o_st_issue_rob   (o_st_issue_rob)
    );

    mem_agu_exec u_mem_agu_exec (
        .clk       (clk),
        .rst       (rst),
        .i_iss_vld (iss_vld),
        .i_iss_op  (iss_op),
        .i_iss_rd  (iss_rd),
        .i_iss_rs1 (iss_rs1),
        .i_iss_rs2 (iss_rs2),
        .i_iss_imm (iss_imm),
        .i_iss_rob (iss_rob),
        .i_wb_vld  (o_wb_vld),
        .i_wb_preg (o_wb_preg),
        .i_wb_data (o_wb_data),
        .o_ex_vld  (ex_vld),
        .o_ex_op   (ex_op),
        .o_ex_rd   (ex_rd),
        .o_ex_addr (ex_addr),
        .o_ex_data (ex_data)
    );

    mem_result_stage #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem_result_stage (
        .clk       (clk),
        .rst       (rst),
        .i_ex_vld  (ex_vld),
        .i_ex_op   (ex_op),
        .i_ex_rd   (ex_rd),
        .i_ex_addr (ex_addr),
        .i_ex_data (ex_data),
        .o_wb_vld  (o_wb_vld),
        .o_wb_preg (o_wb_preg),
        .o_wb_data (o_wb_data),
        .o_st_vld  (o_st_vld),
        .o_st_addr (o_st_addr),
        .o_st_data (o_st_data)
    );

endmodule

/* verification/mem_ref_model.svh */
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// program in dispatch order
logic [INST_W-1:0] prog_inst    [N_OPS];
logic              prog_dep_vld [N_OPS];
logic [ROB_W-1:0]  prog_dep_rob [N_OPS];
int                n_ops;

// in-order model state
logic [DATA_W-1:0] model_regs [NUM_PREGS];
logic [DATA_W-1:0] model_mem  [MEM_WORDS];

// expected results, each register written once and each word stored once
logic [DATA_W-1:0] exp_wb_data [NUM_PREGS];
logic              wb_left     [NUM_PREGS];
logic [DATA_W-1:0] exp_st_addr [MEM_WORDS];
logic [DATA_W-1:0] exp_st_data [MEM_WORDS];
logic              st_left     [MEM_WORDS];
int                n_wb_exp;
int                n_st_exp;

function automatic void clear_model();
    for (int i = 0; i < NUM_PREGS; i++) begin
        model_regs[i]  = '0;
        exp_wb_data[i] = '0;
        wb_left[i]     = 1'b0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
        model_mem[i]   = '0;
        exp_st_addr[i] = '0;
        exp_st_data[i] = '0;
        st_left[i]     = 1'b0;
    end
    n_ops    = 0;
    n_wb_exp = 0;
    n_st_exp = 0;
endfunction

// runs one op in program order and records what must come out of the DUT
function automatic void execute_in_order(input logic [INST_W-1:0] inst);
    mem_op_e               op;
    logic [PREG_W-1:0]     rd;
    logic [PREG_W-1:0]     rs1;
    logic [PREG_W-1:0]     rs2;
    logic [DATA_W-1:0]     imm_ext;
    logic [DATA_W-1:0]     addr;
    logic [MEM_ADDR_W-1:0] word;
    op      = mem_op_e'(inst[1:0]);
    rd      = inst[6:2];
    rs1     = inst[11:7];
    rs2     = inst[16:12];
    imm_ext = {{4{inst[28]}}, inst[28:17]};
    addr    = model_regs[rs1] + imm_ext;
    word    = addr[MEM_ADDR_W-1:0];
    if (op == OP_ST) begin
        model_mem[word]   = model_regs[rs2];
        exp_st_addr[word] = addr;
        exp_st_data[word] = model_regs[rs2];
        st_left[word]     = 1'b1;
        n_st_exp++;
    end else begin
        // LI takes the immediate, LD the word in memory
        model_regs[rd]  = (op == OP_LI) ? imm_ext : model_mem[word];
        exp_wb_data[rd] = model_regs[rd];
        wb_left[rd]     = 1'b1;
        n_wb_exp++;
    end
endfunction

`endif

/* verification/tb_mem_issue_top.sv */
`timescale 1ns/1ps

module tb_mem_issue_top import mem_issue_pkg::*; ();

    localparam int N_OPS       = 32;
    localparam int DEPTH       = 8;
    localparam int MEM_WORDS   = 1 << MEM_ADDR_W;
    localparam int RST_CYCLES  = 16;
    localparam int CYCLE_LIMIT = 40 * N_OPS + 100;

    logic              clk;
    logic              rst;
    logic              i_valid;
    logic [INST_W-1:0] i_inst;
    logic [ROB_W-1:0]  i_rob_idx;
    logic              i_dep_vld;
    logic [ROB_W-1:0]  i_dep_rob_idx;
    logic              o_ready;
    logic              o_wb_vld;
    logic [PREG_W-1:0] o_wb_preg;
    logic [DATA_W-1:0] o_wb_data;
    logic              o_st_vld;
    logic [DATA_W-1:0] o_st_addr;
    logic [DATA_W-1:0] o_st_data;
    logic              o_st_issue_vld;
    logic [ROB_W-1:0]  o_st_issue_rob;

    `include "mem_ref_model.svh"

    integer                seed;
    int                    next_reg;
    int                    cycle_cnt = 0;
    int                    n_wb_seen = 0;
    int                    n_st_seen = 0;
    int                    n_st_iss_seen = 0;
    logic                  saw_full;
    logic                  addr_used [MEM_WORDS];
    logic [ROB_W-1:0]      st_rob    [MEM_WORDS];
    logic                  st_issued [N_OPS];
    logic [MEM_ADDR_W-1:0] st_word;

    mem_issue_top #(
        .DEPTH     (DEPTH),
        .MEM_WORDS (MEM_WORDS)
    ) u_mem_issue_top (
        .clk            (clk),
        .rst            (rst),
        .i_valid        (i_valid),
        .i_inst         (i_inst),
        .i_rob_idx      (i_rob_idx),
        .i_dep_vld      (i_dep_vld),
        .i_dep_rob_idx  (i_dep_rob_idx),
        .o_ready        (o_ready),
        .o_wb_vld       (o_wb_vld),
        .o_wb_preg      (o_wb_preg),
        .o_wb_data      (o_wb_data),
        .o_st_vld       (o_st_vld),
        .o_st_addr      (o_st_addr),
        .o_st_data      (o_st_data),
        .o_st_issue_vld (o_st_issue_vld),
        .o_st_issue_rob (o_st_issue_rob)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic append_op(input mem_op_e op, input logic [PREG_W-1:0] rd,
                             input logic [PREG_W-1:0] rs1, input logic [PREG_W-1:0] rs2,
                             input logic [IMM_W-1:0] imm, input logic dep_vld,
                             input logic [ROB_W-1:0] dep_rob);
        prog_inst[n_ops]    = {3'b000, imm, rs2, rs1, rd, op};
        prog_dep_vld[n_ops] = dep_vld;
        prog_dep_rob[n_ops] = dep_rob;
        execute_in_order(prog_inst[n_ops]);
        n_ops++;
    endtask

    // immediate that takes the base register onto the given word
    function automatic logic [IMM_W-1:0] imm_to_word(input logic [PREG_W-1:0] base,
                                                     input int word, input logic [5:0] upper);
        logic [5:0] low;
        low = 6'(word) - model_regs[base][5:0];
        return {upper, low};
    endfunction

    task automatic pick_written(output logic [PREG_W-1:0] r);
        r = PREG_W'(1 + $unsigned($random(seed)) % (next_reg - 1));
    endtask

    task automatic add_li(output logic [PREG_W-1:0] rd);
        rd = PREG_W'(next_reg);
        next_reg++;
        append_op(OP_LI, rd, '0, '0, IMM_W'($random(seed)), 1'b0, '0);
    endtask

    // stores use words 0..31, each once
    task automatic add_st(input logic [PREG_W-1:0] base, input logic [PREG_W-1:0] data,
                          output int word);
        word = $unsigned($random(seed)) % 32;
        while (addr_used[word]) begin
            word = (word + 1) % 32;
        end
        addr_used[word] = 1'b1;
        st_rob[word]    = ROB_W'(n_ops);
        append_op(OP_ST, '0, base, data, imm_to_word(base, word, 6'($random(seed))), 1'b0, '0);
    endtask

    task automatic add_ld(input logic [PREG_W-1:0] base, input int word, input logic dep,
                          output logic [PREG_W-1:0] rd);
        rd = PREG_W'(next_reg);
        next_reg++;
        append_op(OP_LD, rd, base, '0, imm_to_word(base, word, 6'($random(seed))), dep,
                  dep ? st_rob[word] : '0);
    endtask

    task automatic build_program();
        logic [PREG_W-1:0] r;
        logic [PREG_W-1:0] base;
        logic [PREG_W-1:0] data;
        logic [PREG_W-1:0] chain;
        int                word;
        for (int i = 0; i < 8; i++) begin
            add_li(r);
        end
        // fresh base, then a store and a load that must follow it
        for (int i = 0; i < 3; i++) begin
            add_li(base);
            pick_written(data);
            add_st(base, data, word);
            add_ld(base, word, 1'b1, r);
        end
        // words 32..63 are never stored and read as zero
        pick_written(base);
        add_ld(base, 32 + $unsigned($random(seed)) % 32, 1'b0, r);
        pick_written(chain);
        for (int i = 0; i < 4; i++) begin
            add_ld(chain, 32 + $unsigned($random(seed)) % 32, 1'b0, chain);
        end
        // burst stuck behind the load chain, fills the queue
        for (int i = 0; i < 5; i++) begin
            pick_written(data);
            add_st(chain, data, word);
            add_ld(chain, word, 1'b1, r);
        end
    endtask

    task automatic dispatch_all();
        for (int k = 0; k < n_ops; k++) begin
            i_valid       = 1'b1;
            i_inst        = prog_inst[k];
            i_rob_idx     = ROB_W'(k);
            i_dep_vld     = prog_dep_vld[k];
            i_dep_rob_idx = prog_dep_rob[k];
            @(posedge clk);
            while (!o_ready) begin
                saw_full = 1'b1;
                @(posedge clk);
            end
            #1;
        end
        i_valid = 1'b0;
    endtask

    // result checking, order independent
    always @(posedge clk) begin
        if (!rst && o_wb_vld) begin
            assert (wb_left[o_wb_preg]) else begin
                $display("writeback to p%0d with no op waiting for it at %0t", o_wb_preg, $time);
                stop_on_error();
            end
            assert (o_wb_data == exp_wb_data[o_wb_preg]) else begin
                $display("Fail %0t o_wb_data p%0d: got %h expected %h", $time, o_wb_preg,
                         o_wb_data, exp_wb_data[o_wb_preg]);
                stop_on_error();
            end
            wb_left[o_wb_preg] = 1'b0;
            n_wb_seen++;
        end
        if (!rst && o_st_vld) begin
            st_word = o_st_addr[MEM_ADDR_W-1:0];
            assert (st_left[st_word]) else begin
                $display("store to word %0d with no op waiting for it at %0t", st_word, $time);
                stop_on_error();
            end
            assert (o_st_addr == exp_st_addr[st_word]) else begin
                $display("Fail %0t o_st_addr: got %h expected %h", $time, o_st_addr,
                         exp_st_addr[st_word]);
                stop_on_error();
            end
            assert (o_st_data == exp_st_data[st_word]) else begin
                $display("Fail %0t o_st_data: got %h expected %h", $time, o_st_data,
                         exp_st_data[st_word]);
                stop_on_error();
            end
            st_left[st_word] = 1'b0;
            n_st_seen++;
        end
        // each store of the program issues exactly once
        if (!rst && o_st_issue_vld) begin
            assert ((prog_inst[o_st_issue_rob][1:0] == OP_ST) &&
                    !st_issued[o_st_issue_rob]) else begin
                $display("store issue for ROB %0d that is not a waiting store at %0t",
                         o_st_issue_rob, $time);
                stop_on_error();
            end
            st_issued[o_st_issue_rob] = 1'b1;
            n_st_iss_seen++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        assert (cycle_cnt < CYCLE_LIMIT) else begin
            $display("timeout after %0d cycles, %0d of %0d results seen", cycle_cnt,
                     n_wb_seen + n_st_seen, n_ops);
            stop_on_error();
        end
    end

    initial begin
        seed          = 50;
        rst           = 1'b1;
        i_valid       = 1'b0;
        i_inst        = '0;
        i_rob_idx     = '0;
        i_dep_vld     = 1'b0;
        i_dep_rob_idx = '0;
        saw_full      = 1'b0;
        next_reg      = 1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr_used[i] = 1'b0;
            st_rob[i]    = '0;
        end
        for (int i = 0; i < N_OPS; i++) begin
            st_issued[i] = 1'b0;
        end
        clear_model();
        build_program();
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        repeat (3) begin
            @(posedge clk);
            assert (!o_wb_vld && !o_st_vld && o_ready) else begin
                $display("outputs not idle or not ready after reset at %0t", $time);
                stop_on_error();
            end
        end
        #1;
        dispatch_all();
        while (n_wb_seen + n_st_seen < n_ops) @(negedge clk);
        // leave room for a duplicate result to show up
        repeat (20) @(negedge clk);
        assert (saw_full) else begin
            $display("o_ready never fell during the blocked burst");
            stop_on_error();
        end
        assert (n_st_iss_seen == n_st_exp) else begin
            $display("Fail %0t o_st_issue_vld count: got %0d expected %0d", $time,
                     n_st_iss_seen, n_st_exp);
            stop_on_error();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+verification
hdl/mem_issue_pkg.sv
hdl/age_select.sv
hdl/dispatch_decode.sv
hdl/mem_issue_queue.sv
hdl/mem_agu_exec.sv
hdl/mem_result_stage.sv
hdl/mem_issue_top.sv
verification/tb_mem_issue_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_mem_issue_top -o tb_mem_issue_top

# a fatal stop returns nonzero, the log decides the result
./obj_dir/tb_mem_issue_top > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation passed"
